//--- design/mips_consts.svh
// Width, register file size and reset constants for the MIPS core
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Machine word, also used for addresses and instructions
`define DATA_W 32

// Register file
`define NUM_REGS 32
`define REG_IDX_W 5

// Immediate field of I-type instructions
`define IMM_W 16

// Byte step between consecutive instructions
`define INSTR_BYTES 32'd4

// Program counter after reset
`define RESET_PC 32'h0000_0000

`endif

//--- design/mipsPkg.sv
// Word and register index types, opcode, funct and ALU control enums
`include "mips_consts.svh"

package mipsPkg;

  typedef logic [`DATA_W-1:0] word_t;
  typedef logic [`REG_IDX_W-1:0] regIdx_t;

  typedef enum logic [5:0] {
    OP_RTYPE = 6'b000000,
    OP_BEQ   = 6'b000100,
    OP_ADDI  = 6'b001000,
    OP_LW    = 6'b100011,
    OP_SW    = 6'b101011
  } opcode_t;

  typedef enum logic [5:0] {
    FN_ADD = 6'b100000,
    FN_SUB = 6'b100010,
    FN_AND = 6'b100100,
    FN_OR  = 6'b100101,
    FN_SLT = 6'b101010
  } funct_t;

  typedef enum logic [2:0] {
    ALU_AND = 3'b000,
    ALU_OR  = 3'b001,
    ALU_ADD = 3'b010,
    ALU_SUB = 3'b110,
    ALU_SLT = 3'b111
  } aluCtrl_t;

  // Between main decoder and ALU decoder only
  typedef enum logic [1:0] {
    ALUOP_ADD   = 2'b00,
    ALUOP_SUB   = 2'b01,
    ALUOP_FUNCT = 2'b10
  } aluOp_t;

endpackage

//--- design/controlUnit.sv
// Control unit with main decoder and ALU decoder
`timescale 1ns/10ps

module controlUnit (
  input  mipsPkg::opcode_t  opcode,
  input  mipsPkg::funct_t   funct,
  output logic              regWrite,
  output logic              regDst,
  output logic              aluSrc,
  output logic              branch,
  output logic              memWrite,
  output logic              memToReg,
  output mipsPkg::aluCtrl_t aluCtrl
);

  import mipsPkg::*;

  aluOp_t aluOp;

  // Main decoder
  always_comb begin
    case (opcode)
      OP_RTYPE: begin
        regWrite = 1'b1;
        regDst   = 1'b1; // rd is the destination
        aluSrc   = 1'b0;
        branch   = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        aluOp    = ALUOP_FUNCT;
      end
      OP_LW: begin
        regWrite = 1'b1;
        regDst   = 1'b0;
        aluSrc   = 1'b1; // Base plus offset
        branch   = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b1;
        aluOp    = ALUOP_ADD;
      end
      OP_SW: begin
        regWrite = 1'b0;
        regDst   = 1'b0;
        aluSrc   = 1'b1;
        branch   = 1'b0;
        memWrite = 1'b1;
        memToReg = 1'b0;
        aluOp    = ALUOP_ADD;
      end
      OP_BEQ: begin
        regWrite = 1'b0;
        regDst   = 1'b0;
        aluSrc   = 1'b0;
        branch   = 1'b1;
        memWrite = 1'b0;
        memToReg = 1'b0;
        aluOp    = ALUOP_SUB; // Equal operands give zero
      end
      OP_ADDI: begin
        regWrite = 1'b1;
        regDst   = 1'b0;
        aluSrc   = 1'b1;
        branch   = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        aluOp    = ALUOP_ADD;
      end
      default: begin // Unknown opcode has no side effect
        regWrite = 1'b0;
        regDst   = 1'b0;
        aluSrc   = 1'b0;
        branch   = 1'b0;
        memWrite = 1'b0;
        memToReg = 1'b0;
        aluOp    = ALUOP_ADD;
      end
    endcase
  end

  // ALU decoder
  always_comb begin
    case (aluOp)
      ALUOP_SUB: aluCtrl = ALU_SUB;
      ALUOP_FUNCT: begin
        case (funct)
          FN_ADD:  aluCtrl = ALU_ADD;
          FN_SUB:  aluCtrl = ALU_SUB;
          FN_AND:  aluCtrl = ALU_AND;
          FN_OR:   aluCtrl = ALU_OR;
          FN_SLT:  aluCtrl = ALU_SLT;
          default: aluCtrl = ALU_ADD;
        endcase
      end
      default: aluCtrl = ALU_ADD;
    endcase
  end

endmodule

//--- design/alu.sv
// 32-bit ALU with and, or, add, sub, signed slt and zero flag
`timescale 1ns/10ps
`include "mips_consts.svh"

module alu (
  input  mipsPkg::word_t    a,
  input  mipsPkg::word_t    b,
  input  mipsPkg::aluCtrl_t ctrl,
  output mipsPkg::word_t    result,
  output logic              zero
);

  import mipsPkg::*;

  logic lessThan;

  // Two's complement compare
  assign lessThan = $signed(a) < $signed(b);

  always_comb begin
    case (ctrl)
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_ADD: result = a + b; // Wraps at 32 bits
      ALU_SUB: result = a - b;
      ALU_SLT: result = {{(`DATA_W-1){1'b0}}, lessThan};
      default: result = '0;
    endcase
  end

  assign zero = (result == '0);

endmodule

//--- design/regFile.sv
// Register file with two combinational reads, one clocked write, r0 fixed at zero
`timescale 1ns/10ps
`include "mips_consts.svh"

module regFile (
  input  logic            clk,
  input  logic            rst,
  input  mipsPkg::regIdx_t readAddr1,
  input  mipsPkg::regIdx_t readAddr2,
  input  mipsPkg::regIdx_t writeAddr,
  input  mipsPkg::word_t   writeData,
  input  logic            writeEn,
  output mipsPkg::word_t   readData1,
  output mipsPkg::word_t   readData2
);

  import mipsPkg::*;

  word_t regs [`NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEn && (writeAddr != '0)) begin // r0 is read-only
      regs[writeAddr] <= writeData;
    end
  end

  // New value visible the cycle after the write edge
  assign readData1 = (readAddr1 == '0) ? '0 : regs[readAddr1];
  assign readData2 = (readAddr2 == '0) ? '0 : regs[readAddr2];

endmodule

//--- design/mipsCore.sv
// Single-cycle MIPS core top with PC, datapath muxes, control unit, register file and ALU
`timescale 1ns/10ps
`include "mips_consts.svh"

module mipsCore (
  input  logic           clk,
  input  logic           rst,
  output mipsPkg::word_t instrAddr,
  input  mipsPkg::word_t instr,
  output mipsPkg::word_t dataAddr,
  output mipsPkg::word_t dataWData,
  output logic           dataWrite,
  input  mipsPkg::word_t dataRData
);

  import mipsPkg::*;

  // Program counter
  word_t pc;
  word_t pcPlus4;
  word_t branchTarget;
  word_t nextPc;
  logic  pcSrc;

  // Instruction fields
  opcode_t              opcode;
  funct_t               funct;
  regIdx_t              rs;
  regIdx_t              rt;
  regIdx_t              rd;
  logic [`IMM_W-1:0]    imm;
  word_t                signImm;

  // Control
  logic     regWrite;
  logic     regDst;
  logic     aluSrc;
  logic     branch;
  logic     memWrite;
  logic     memToReg;
  aluCtrl_t aluCtrl;

  // Datapath
  regIdx_t writeIdx;
  word_t   readData1;
  word_t   readData2;
  word_t   aluB;
  word_t   aluResult;
  logic    aluZero;
  word_t   writeBack;

  assign opcode = opcode_t'(instr[31:26]);
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];
  assign imm    = instr[`IMM_W-1:0];
  assign funct  = funct_t'(instr[5:0]);

  assign signImm = {{(`DATA_W-`IMM_W){imm[`IMM_W-1]}}, imm};

  controlUnit control (
    .opcode   (opcode),
    .funct    (funct),
    .regWrite (regWrite),
    .regDst   (regDst),
    .aluSrc   (aluSrc),
    .branch   (branch),
    .memWrite (memWrite),
    .memToReg (memToReg),
    .aluCtrl  (aluCtrl)
  );

  assign writeIdx  = regDst ? rd : rt; // R-type writes rd
  assign writeBack = memToReg ? dataRData : aluResult;

  regFile regs (
    .clk       (clk),
    .rst       (rst),
    .readAddr1 (rs),
    .readAddr2 (rt),
    .writeAddr (writeIdx),
    .writeData (writeBack),
    .writeEn   (regWrite),
    .readData1 (readData1),
    .readData2 (readData2)
  );

  assign aluB = aluSrc ? signImm : readData2;

  alu alu0 (
    .a      (readData1),
    .b      (aluB),
    .ctrl   (aluCtrl),
    .result (aluResult),
    .zero   (aluZero)
  );

  // Next PC
  assign pcPlus4      = pc + `INSTR_BYTES;
  assign branchTarget = pcPlus4 + {signImm[`DATA_W-3:0], 2'b00};
  assign pcSrc        = branch & aluZero;
  assign nextPc       = pcSrc ? branchTarget : pcPlus4;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else begin
      pc <= nextPc;
    end
  end

  assign instrAddr = pc;
  assign dataAddr  = aluResult;
  assign dataWData = readData2;
  assign dataWrite = memWrite; // Store commits at the next edge

endmodule

//--- sim/mips_asserts.sv
// Concurrent assertions on fetch address and store strobe of mipsCore
`timescale 1ns/10ps

module mips_asserts (
  input logic           clk,
  input logic           rst,
  input mipsPkg::word_t instrAddr,
  input mipsPkg::word_t instr,
  input logic           dataWrite
);

  import mipsPkg::*;

  int failCount = 0;

  writeKnown: assert property (@(posedge clk) disable iff (rst) !$isunknown(dataWrite))
    else begin
      $error("dataWrite is unknown");
      failCount++;
    end

  // PC only moves in whole words
  fetchAligned: assert property (@(posedge clk) disable iff (rst) instrAddr[1:0] == 2'b00)
    else begin
      $error("instrAddr %h is not word aligned", instrAddr);
      failCount++;
    end

  storeOnlySw: assert property (@(posedge clk) disable iff (rst)
                                dataWrite |-> instr[31:26] == OP_SW)
    else begin
      $error("dataWrite high for opcode %b", instr[31:26]);
      failCount++;
    end

endmodule

bind mipsCore mips_asserts assertCheck (
  .clk       (clk),
  .rst       (rst),
  .instrAddr (instrAddr),
  .instr     (instr),
  .dataWrite (dataWrite)
);

//--- sim/tb_mips.sv
// Testbench for mipsCore with memory models, encoders, compare tasks and directed tests
`timescale 1ns/10ps
`include "mips_consts.svh"

module tb_mips;

  import mipsPkg::*;

  localparam int MEM_WORDS    = 256;
  localparam int RESET_CYCLES = 10;
  localparam int MAX_CYCLES   = 2000; // Six tests need under 300 cycles together

  logic  clk;
  logic  rst;
  logic  loadData;
  word_t instrAddr;
  word_t instr;
  word_t dataAddr;
  word_t dataWData;
  logic  dataWrite;
  word_t dataRData;

  word_t imem [MEM_WORDS];
  word_t dmem [MEM_WORDS];
  word_t prog [$];
  word_t preData [$];
  word_t storeAddrQ [$];
  word_t storeDataQ [$];
  word_t pcTrace [$];
  logic  writeTrace [$];
  word_t randState;
  int    storeIdx;
  int    errors;
  int    cycles;

  mipsCore uut (
    .clk       (clk),
    .rst       (rst),
    .instrAddr (instrAddr),
    .instr     (instr),
    .dataAddr  (dataAddr),
    .dataWData (dataWData),
    .dataWrite (dataWrite),
    .dataRData (dataRData)
  );

  always #5 clk = ~clk;

  // Nop during reset, word-addressed memories otherwise
  assign instr     = rst ? '0 : imem[instrAddr[9:2]];
  assign dataRData = dmem[dataAddr[9:2]];

  // Data memory, store monitor and fetch trace
  always @(posedge clk) begin
    if (rst) begin
      storeAddrQ.delete();
      storeDataQ.delete();
      pcTrace.delete();
      writeTrace.delete();
      if (loadData) begin
        for (int i = 0; i < MEM_WORDS; i++) begin
          dmem[i] <= (i < preData.size()) ? preData[i] : '0;
        end
      end
    end else begin
      pcTrace.push_back(instrAddr);
      writeTrace.push_back(dataWrite);
      if (dataWrite) begin
        storeAddrQ.push_back(dataAddr);
        storeDataQ.push_back(dataWData);
        dmem[dataAddr[9:2]] <= dataWData;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles", cycles);
      $display("test failed");
      $finish;
    end
  end

  function automatic word_t xorshift32(input word_t s);
    word_t x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic word_t iType(input opcode_t op, input int rt, input int rs, input int imm);
    return {op, regIdx_t'(rs), regIdx_t'(rt), 16'(imm)};
  endfunction

  function automatic word_t rType(input funct_t fn, input int rd, input int rs, input int rt);
    return {OP_RTYPE, regIdx_t'(rs), regIdx_t'(rt), regIdx_t'(rd), 5'd0, fn};
  endfunction

  // Immediate as the core sees it
  function automatic word_t sext16(input int v);
    return {{16{v[15]}}, v[15:0]};
  endfunction

  task automatic checkWord(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      errors++;
      $display("ERR %s expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic expectStore(input string name, input word_t addr, input word_t data);
    if (storeIdx >= storeAddrQ.size()) begin
      errors++;
      $display("%s: store %0d to address %h never happened", name, storeIdx, addr);
    end else begin
      checkWord(name, addr, storeAddrQ[storeIdx]);
      checkWord(name, data, storeDataQ[storeIdx]);
    end
    storeIdx++;
  endtask

  task automatic noMoreStores(input string name);
    if (storeAddrQ.size() > storeIdx) begin
      errors++;
      $display("%s: %0d unexpected stores, first to address %h", name,
               storeAddrQ.size() - storeIdx, storeAddrQ[storeIdx]);
    end
  endtask

  // Loads prog and preData under reset, then runs until the PC passes the last instruction
  task automatic runProgram(input string name);
    word_t endAddr;
    int    waited;
    endAddr = 4 * prog.size();
    @(posedge clk);
    rst      <= 1'b1;
    loadData <= 1'b1;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] <= (i < prog.size()) ? prog[i] : '0;
    end
    @(posedge clk);
    loadData <= 1'b0;
    repeat (RESET_CYCLES - 1) @(posedge clk);
    rst <= 1'b0;
    storeIdx = 0;
    waited   = 0;
    do begin
      @(negedge clk);
      waited++;
    end while (instrAddr !== endAddr && waited < prog.size() + 8);
    if (instrAddr !== endAddr) begin
      errors++;
      $display("%s: program never reached its end address %h", name, endAddr);
    end
  endtask

  task automatic testArith();
    word_t a;
    word_t b;
    a = sext16(1234);
    b = sext16(-300);
    prog.delete();
    preData.delete();
    prog.push_back(iType(OP_ADDI, 1, 0, 1234));
    prog.push_back(iType(OP_ADDI, 2, 0, -300));
    prog.push_back(rType(FN_ADD, 3, 1, 2));
    prog.push_back(rType(FN_SUB, 4, 1, 2));
    prog.push_back(rType(FN_AND, 5, 1, 2));
    prog.push_back(rType(FN_OR, 6, 1, 2));
    for (int i = 0; i < 4; i++) begin
      prog.push_back(iType(OP_SW, 3 + i, 0, 4 * i));
    end
    runProgram("arith");
    expectStore("arith", 32'd0, a + b);
    expectStore("arith", 32'd4, a - b);
    expectStore("arith", 32'd8, a & b);
    expectStore("arith", 32'd12, a | b);
    noMoreStores("arith");
  endtask

  task automatic testLoadStore();
    prog.delete();
    preData.delete();
    preData.push_back(32'hDEAD_BEEF);
    preData.push_back(32'h1234_5678);
    preData.push_back(32'h0F0F_0F0F);
    prog.push_back(iType(OP_LW, 2, 0, 0));
    prog.push_back(iType(OP_LW, 3, 0, 4));
    prog.push_back(iType(OP_LW, 4, 0, 8));
    prog.push_back(iType(OP_ADDI, 1, 0, 32)); // Store base
    prog.push_back(iType(OP_SW, 2, 1, 0));
    prog.push_back(iType(OP_SW, 3, 1, 8));
    prog.push_back(iType(OP_SW, 4, 1, -4));
    runProgram("loadStore");
    expectStore("loadStore", 32'd32 + sext16(0), 32'hDEAD_BEEF);
    expectStore("loadStore", 32'd32 + sext16(8), 32'h1234_5678);
    expectStore("loadStore", 32'd32 + sext16(-4), 32'h0F0F_0F0F);
    noMoreStores("loadStore");
  endtask

  task automatic testBranch();
    word_t expPc [7];
    prog.delete();
    preData.delete();
    prog.push_back(iType(OP_ADDI, 1, 0, 5));
    prog.push_back(iType(OP_ADDI, 2, 0, 5));
    prog.push_back(iType(OP_ADDI, 3, 0, 7));
    prog.push_back(iType(OP_BEQ, 2, 1, 1)); // Equal, skips next
    prog.push_back(iType(OP_SW, 1, 0, 'h40)); // Skipped path marker
    prog.push_back(iType(OP_SW, 2, 0, 'h44));
    prog.push_back(iType(OP_BEQ, 3, 1, 1)); // Unequal, falls through
    prog.push_back(iType(OP_SW, 3, 0, 'h48));
    // Taken beq at 12 goes to 12 + 4 + 4 * 1
    expPc = '{32'd0, 32'd4, 32'd8, 32'd12, 32'd20, 32'd24, 32'd28};
    runProgram("branch");
    if (pcTrace.size() != 7) begin
      errors++;
      $display("branch: %0d instructions retired instead of 7", pcTrace.size());
    end else begin
      for (int i = 0; i < 7; i++) begin
        checkWord("branch", expPc[i], pcTrace[i]);
      end
    end
    expectStore("branch", 32'h44, 32'd5);
    expectStore("branch", 32'h48, 32'd7);
    noMoreStores("branch");
  endtask

  task automatic testSltZero();
    word_t v [3];
    v = '{sext16(-5), sext16(3), sext16(-9)};
    prog.delete();
    preData.delete();
    prog.push_back(iType(OP_ADDI, 1, 0, -5));
    prog.push_back(iType(OP_ADDI, 2, 0, 3));
    prog.push_back(iType(OP_ADDI, 3, 0, -9));
    prog.push_back(rType(FN_SLT, 4, 1, 2));
    prog.push_back(rType(FN_SLT, 5, 2, 1));
    prog.push_back(rType(FN_SLT, 6, 3, 1));
    prog.push_back(rType(FN_SLT, 7, 1, 3));
    prog.push_back(iType(OP_ADDI, 0, 0, 77)); // Must not change r0
    for (int i = 0; i < 4; i++) begin
      prog.push_back(iType(OP_SW, 4 + i, 0, 4 * i));
    end
    prog.push_back(iType(OP_SW, 0, 0, 16));
    runProgram("sltZero");
    expectStore("sltZero", 32'd0, ($signed(v[0]) < $signed(v[1])) ? 32'd1 : 32'd0);
    expectStore("sltZero", 32'd4, ($signed(v[1]) < $signed(v[0])) ? 32'd1 : 32'd0);
    expectStore("sltZero", 32'd8, ($signed(v[2]) < $signed(v[0])) ? 32'd1 : 32'd0);
    expectStore("sltZero", 32'd12, ($signed(v[0]) < $signed(v[2])) ? 32'd1 : 32'd0);
    expectStore("sltZero", 32'd16, 32'd0);
    noMoreStores("sltZero");
  endtask

  task automatic testRandom();
    word_t x [10];
    word_t y [10];
    prog.delete();
    preData.delete();
    for (int i = 0; i < 10; i++) begin
      randState = xorshift32(randState);
      x[i] = sext16(int'(randState[15:0]));
      randState = xorshift32(randState);
      y[i] = sext16(int'(randState[15:0]));
      prog.push_back(iType(OP_ADDI, 1, 0, int'(x[i][15:0])));
      prog.push_back(iType(OP_ADDI, 2, 0, int'(y[i][15:0])));
      prog.push_back(rType(FN_ADD, 3, 1, 2));
      prog.push_back(rType(FN_SUB, 4, 1, 2));
      prog.push_back(iType(OP_SW, 3, 0, 8 * i));
      prog.push_back(iType(OP_SW, 4, 0, 8 * i + 4));
    end
    runProgram("random");
    for (int i = 0; i < 10; i++) begin
      expectStore("random", 8 * i, x[i] + y[i]);
      expectStore("random", 8 * i + 4, x[i] - y[i]);
    end
    noMoreStores("random");
  endtask

  task automatic testUnknownOp();
    prog.delete();
    preData.delete();
    prog.push_back(iType(OP_ADDI, 1, 0, 'h111));
    prog.push_back(iType(OP_ADDI, 2, 0, 'h222));
    prog.push_back(iType(OP_SW, 1, 0, 0));
    prog.push_back(32'hFC22_0004); // Opcode 111111, looks like addi r2, r1, 4
    prog.push_back(iType(OP_SW, 2, 0, 4));
    runProgram("unknownOp");
    if (pcTrace.size() != 5) begin
      errors++;
      $display("unknownOp: %0d instructions retired instead of 5", pcTrace.size());
    end else begin
      checkBit("unknownOp", 1'b0, writeTrace[3]);
      checkWord("unknownOp", 32'd12 + 32'd4, pcTrace[4]);
    end
    expectStore("unknownOp", 32'd0, 32'h111);
    expectStore("unknownOp", 32'd4, 32'h222);
    noMoreStores("unknownOp");
  endtask

  initial begin
    clk       = 1'b0;
    rst       = 1'b1;
    loadData  = 1'b0;
    randState = 32'd90478;
    storeIdx  = 0;
    errors    = 0;
    cycles    = 0;
    testArith();
    testLoadStore();
    testBranch();
    testSltZero();
    testRandom();
    testUnknownOp();
    errors += uut.assertCheck.failCount;
    $display("Errors: %0d (assertion failures: %0d)", errors, uut.assertCheck.failCount);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- all.f
+incdir+design
design/mipsPkg.sv
design/controlUnit.sv
design/alu.sv
design/regFile.sv
design/mipsCore.sv
sim/mips_asserts.sv
sim/tb_mips.sv

//--- run.sh
#!/bin/sh
# Builds the MIPS core testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_mips

verilator --binary --timing --assert -f all.f --top-module "$TOP" -Mdir "$BUILD_DIR"
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/V$TOP" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$LOG"; then
  echo "Simulation reported failure, see $LOG"
  exit 1
fi

if ! grep -q "test passed" "$LOG"; then
  echo "Simulation ended without a verdict, see $LOG"
  exit 1
fi

exit 0
